// File: verilog/stage1_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 1 sizes for the issue queue, register scoreboard and branch tags.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef STAGE1_CFG_SVH
`define STAGE1_CFG_SVH

// issue queue entries.
`define QUEUE_DEPTH 16

// architectural registers tracked by the scoreboard.
`define REG_COUNT 16

// oldest queue entries looked at for issue each cycle.
`define WINDOW 4

// branches allowed in the queue at once.
`define BRANCH_LIMIT 4

// speculation ids, a power of two so the tag counter wraps by itself.
`define TAG_COUNT 8

`endif

// File: verilog/isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ISA package. Instruction field types and the opcodes stage 1 decodes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "stage1_cfg.svh"

package isa_pkg;

	// register number, source or destination.
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

	typedef logic [3:0] opcode_t;

	// small immediate carried through untouched.
	typedef logic [3:0] imm_t;

	// no destination write, never marks the scoreboard.
	localparam opcode_t OP_NOP = 4'h0;

	// opens a new speculation region for younger instructions.
	localparam opcode_t OP_BRANCH = 4'hf;

endpackage

// File: verilog/queue_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Queue package. Index, count, speculation tag and window mask types.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "stage1_cfg.svh"

package queue_pkg;

	// branch speculation id.
	typedef logic [$clog2(`TAG_COUNT)-1:0] branch_tag_t;

	// position in the queue, 0 is the oldest entry.
	typedef logic [$clog2(`QUEUE_DEPTH)-1:0] q_idx_t;

	// occupancy, one wider than the index so a full queue fits.
	typedef logic [$clog2(`QUEUE_DEPTH+1)-1:0] q_count_t;

	// one bit per issue window slot.
	typedef logic [`WINDOW-1:0] slot_mask_t;

endpackage

// File: verilog/issue_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue queue. Age-ordered storage with two-wide enqueue and branch tags,
// removal of issued window entries with compaction, and branch flush.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "stage1_cfg.svh"

module issue_queue import isa_pkg::*, queue_pkg::*; (
	input logic clk,
	input logic arst_n,

	input logic ins_new_en,
	input logic ins_new_1_vld,
	input logic ins_new_2_vld,

	input reg_idx_t ins_1_des, ins_1_s1, ins_1_s2,
	input opcode_t ins_1_op,
	input imm_t ins_1_ime,

	input reg_idx_t ins_2_des, ins_2_s1, ins_2_s2,
	input opcode_t ins_2_op,
	input imm_t ins_2_ime,

	input logic flush_en,
	input branch_tag_t flush_id,
	input slot_mask_t issue_mask,

	output logic entry_full,
	output logic entry_empty,
	output logic branch_full,

	output logic win_1_vld,
	output reg_idx_t win_1_des, win_1_s1, win_1_s2,
	output opcode_t win_1_op,
	output branch_tag_t win_1_branch,
	output imm_t win_1_ime,

	output logic win_2_vld,
	output reg_idx_t win_2_des, win_2_s1, win_2_s2,
	output opcode_t win_2_op,
	output branch_tag_t win_2_branch,
	output imm_t win_2_ime,

	output logic win_3_vld,
	output reg_idx_t win_3_des, win_3_s1, win_3_s2,
	output opcode_t win_3_op,
	output branch_tag_t win_3_branch,
	output imm_t win_3_ime,

	output logic win_4_vld,
	output reg_idx_t win_4_des, win_4_s1, win_4_s2,
	output opcode_t win_4_op,
	output branch_tag_t win_4_branch,
	output imm_t win_4_ime
);

	localparam int TAG_W = $bits(branch_tag_t);
	localparam int OP_W = $bits(opcode_t);
	// entry layout {op, des, s1, s2, ime, tag}.
	localparam int ENTRY_W = OP_W + 3 * $bits(reg_idx_t) + $bits(imm_t) + TAG_W;

	logic [ENTRY_W-1:0] q_mem [`QUEUE_DEPTH];
	logic [ENTRY_W-1:0] n_mem [`QUEUE_DEPTH];
	q_count_t count, n_count;
	q_count_t br_count, n_br_count;
	q_count_t cut, pos;
	branch_tag_t tag_ctr, n_tag_ctr;
	branch_tag_t tag_1, tag_2;
	logic [`QUEUE_DEPTH-1:0] issued;
	logic br_1, br_2, accept;

	function automatic logic is_branch(input logic [ENTRY_W-1:0] e);
		return e[ENTRY_W-1 -: OP_W] == OP_BRANCH;
	endfunction

	assign br_1 = ins_new_1_vld && ins_1_op == OP_BRANCH;
	assign br_2 = ins_new_2_vld && ins_2_op == OP_BRANCH;
	// the pair goes in whole or not at all.
	assign accept = ins_new_en && !flush_en && !entry_full && !((br_1 || br_2) && branch_full);

	assign tag_1 = tag_ctr;
	assign tag_2 = tag_ctr + branch_tag_t'(br_1); // sees a branch in slot 1.
	assign issued = {{(`QUEUE_DEPTH-`WINDOW){1'b0}}, issue_mask};

	always_comb begin
		n_mem = q_mem;
		n_count = count;
		n_tag_ctr = tag_ctr;
		pos = '0;
		cut = count;
		if (flush_en) begin
			// walk young to old so the oldest match is left in cut.
			for (int i = `QUEUE_DEPTH - 1; i >= 0; i--) begin
				if (q_count_t'(i) < count && q_mem[i][TAG_W-1:0] == flush_id)
					cut = q_count_t'(i);
			end
			n_count = cut;
			n_tag_ctr = flush_id;
		end else begin
			for (int i = 0; i < `QUEUE_DEPTH; i++) begin
				if (q_count_t'(i) < count && !issued[i]) begin
					n_mem[q_idx_t'(pos)] = q_mem[i];
					pos++;
				end
			end
			if (accept && ins_new_1_vld) begin
				n_mem[q_idx_t'(pos)] = {ins_1_op, ins_1_des, ins_1_s1, ins_1_s2, ins_1_ime, tag_1};
				pos++;
			end
			if (accept && ins_new_2_vld) begin
				n_mem[q_idx_t'(pos)] = {ins_2_op, ins_2_des, ins_2_s1, ins_2_s2, ins_2_ime, tag_2};
				pos++;
			end
			n_count = pos;
			if (accept)
				n_tag_ctr = tag_ctr + branch_tag_t'(br_1) + branch_tag_t'(br_2);
		end
	end

	// recount branches over what stays, covers issue and flush alike.
	always_comb begin
		n_br_count = '0;
		for (int i = 0; i < `QUEUE_DEPTH; i++) begin
			if (q_count_t'(i) < n_count && is_branch(n_mem[i]))
				n_br_count = n_br_count + q_count_t'(1);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
			br_count <= '0;
			tag_ctr <= '0;
		end else begin
			count <= n_count;
			br_count <= n_br_count;
			tag_ctr <= n_tag_ctr;
		end
	end

	always_ff @(posedge clk) begin
		q_mem <= n_mem;
	end

	assign entry_full = count > q_count_t'(`QUEUE_DEPTH - 2); // room for a pair.
	assign entry_empty = count == '0;
	assign branch_full = br_count >= q_count_t'(`BRANCH_LIMIT);

	assign win_1_vld = count > q_count_t'(0);
	assign win_2_vld = count > q_count_t'(1);
	assign win_3_vld = count > q_count_t'(2);
	assign win_4_vld = count > q_count_t'(3);

	assign {win_1_op, win_1_des, win_1_s1, win_1_s2, win_1_ime, win_1_branch} = q_mem[0];
	assign {win_2_op, win_2_des, win_2_s1, win_2_s2, win_2_ime, win_2_branch} = q_mem[1];
	assign {win_3_op, win_3_des, win_3_s1, win_3_s2, win_3_ime, win_3_branch} = q_mem[2];
	assign {win_4_op, win_4_des, win_4_s1, win_4_s2, win_4_ime, win_4_branch} = q_mem[3];

endmodule

// File: verilog/hazard_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard checker. Register busy scoreboard and issue eligibility for the
// four window slots, against the scoreboard and older slots.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "stage1_cfg.svh"

module hazard_checker import isa_pkg::*, queue_pkg::*; (
	input logic clk,
	input logic arst_n,

	input logic win_1_vld,
	input reg_idx_t win_1_des, win_1_s1, win_1_s2,
	input opcode_t win_1_op,

	input logic win_2_vld,
	input reg_idx_t win_2_des, win_2_s1, win_2_s2,
	input opcode_t win_2_op,

	input logic win_3_vld,
	input reg_idx_t win_3_des, win_3_s1, win_3_s2,
	input opcode_t win_3_op,

	input logic win_4_vld,
	input reg_idx_t win_4_des, win_4_s1, win_4_s2,
	input opcode_t win_4_op,

	input logic ins_back_1, ins_back_2, ins_back_3, ins_back_4,
	input reg_idx_t ins_back_1_des, ins_back_2_des, ins_back_3_des, ins_back_4_des,

	input logic flush_en,
	input logic [`REG_COUNT-1:0] flush_reg,

	output slot_mask_t issue_mask
);

	localparam int BACK_PORTS = 4;

	logic [`REG_COUNT-1:0] busy, busy_nxt;
	logic [`WINDOW-1:0] w_vld, elig;
	logic [BACK_PORTS-1:0] back;
	reg_idx_t w_des [`WINDOW];
	reg_idx_t w_s1 [`WINDOW];
	reg_idx_t w_s2 [`WINDOW];
	opcode_t w_op [`WINDOW];
	reg_idx_t back_des [BACK_PORTS];

	assign w_vld = {win_4_vld, win_3_vld, win_2_vld, win_1_vld};
	assign w_des = '{win_1_des, win_2_des, win_3_des, win_4_des};
	assign w_s1 = '{win_1_s1, win_2_s1, win_3_s1, win_4_s1};
	assign w_s2 = '{win_1_s2, win_2_s2, win_3_s2, win_4_s2};
	assign w_op = '{win_1_op, win_2_op, win_3_op, win_4_op};
	assign back = {ins_back_4, ins_back_3, ins_back_2, ins_back_1};
	assign back_des = '{ins_back_1_des, ins_back_2_des, ins_back_3_des, ins_back_4_des};

	always_comb begin
		for (int k = 0; k < `WINDOW; k++) begin
			elig[k] = w_vld[k] && !busy[w_s1[k]] && !busy[w_s2[k]] && !busy[w_des[k]];
			// every older valid writer blocks, issuing or not.
			for (int j = 0; j < k; j++) begin
				if (w_vld[j] && w_op[j] != OP_NOP &&
				    (w_des[j] == w_s1[k] || w_des[j] == w_s2[k] || w_des[j] == w_des[k]))
					elig[k] = 1'b0;
			end
		end
	end

	assign issue_mask = flush_en ? '0 : elig; // nothing leaves during a flush.

	always_comb begin
		busy_nxt = busy;
		for (int b = 0; b < BACK_PORTS; b++) begin
			if (back[b])
				busy_nxt[back_des[b]] = 1'b0;
		end
		if (flush_en)
			busy_nxt = busy_nxt & ~flush_reg;
		// sets come last so they win over a writeback to the same register.
		for (int k = 0; k < `WINDOW; k++) begin
			if (issue_mask[k] && w_op[k] != OP_NOP)
				busy_nxt[w_des[k]] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			busy <= '0;
		else
			busy <= busy_nxt;
	end

endmodule

// File: verilog/issue_swap.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue packer. Moves the selected window slots, oldest first, onto the
// four registered issue slots.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "stage1_cfg.svh"

module issue_swap import isa_pkg::*, queue_pkg::*; (
	input logic clk,
	input logic arst_n,

	input logic win_1_vld,
	input reg_idx_t win_1_des, win_1_s1, win_1_s2,
	input opcode_t win_1_op,
	input branch_tag_t win_1_branch,
	input imm_t win_1_ime,

	input logic win_2_vld,
	input reg_idx_t win_2_des, win_2_s1, win_2_s2,
	input opcode_t win_2_op,
	input branch_tag_t win_2_branch,
	input imm_t win_2_ime,

	input logic win_3_vld,
	input reg_idx_t win_3_des, win_3_s1, win_3_s2,
	input opcode_t win_3_op,
	input branch_tag_t win_3_branch,
	input imm_t win_3_ime,

	input logic win_4_vld,
	input reg_idx_t win_4_des, win_4_s1, win_4_s2,
	input opcode_t win_4_op,
	input branch_tag_t win_4_branch,
	input imm_t win_4_ime,

	input slot_mask_t issue_mask,

	output logic out_1_vld,
	output reg_idx_t out_1_des, out_1_s1, out_1_s2,
	output opcode_t out_1_op,
	output branch_tag_t out_1_branch,
	output imm_t out_1_ime,

	output logic out_2_vld,
	output reg_idx_t out_2_des, out_2_s1, out_2_s2,
	output opcode_t out_2_op,
	output branch_tag_t out_2_branch,
	output imm_t out_2_ime,

	output logic out_3_vld,
	output reg_idx_t out_3_des, out_3_s1, out_3_s2,
	output opcode_t out_3_op,
	output branch_tag_t out_3_branch,
	output imm_t out_3_ime,

	output logic out_4_vld,
	output reg_idx_t out_4_des, out_4_s1, out_4_s2,
	output opcode_t out_4_op,
	output branch_tag_t out_4_branch,
	output imm_t out_4_ime
);

	localparam int SLOT_W = 3 * $bits(reg_idx_t) + $bits(opcode_t) + $bits(branch_tag_t) +
		$bits(imm_t);

	logic [SLOT_W-1:0] win_e [`WINDOW];
	logic [SLOT_W-1:0] pack_e [`WINDOW];
	logic [SLOT_W-1:0] out_e [`WINDOW];
	logic [`WINDOW-1:0] sel, pack_vld, out_vld;
	logic [$clog2(`WINDOW)-1:0] pos;

	assign win_e[0] = {win_1_des, win_1_s1, win_1_s2, win_1_op, win_1_branch, win_1_ime};
	assign win_e[1] = {win_2_des, win_2_s1, win_2_s2, win_2_op, win_2_branch, win_2_ime};
	assign win_e[2] = {win_3_des, win_3_s1, win_3_s2, win_3_op, win_3_branch, win_3_ime};
	assign win_e[3] = {win_4_des, win_4_s1, win_4_s2, win_4_op, win_4_branch, win_4_ime};

	assign sel = issue_mask & {win_4_vld, win_3_vld, win_2_vld, win_1_vld};

	// each selected slot lands on the next free output, age order kept.
	always_comb begin
		pack_e = win_e;
		pack_vld = '0;
		pos = '0;
		for (int k = 0; k < `WINDOW; k++) begin
			if (sel[k]) begin
				pack_e[pos] = win_e[k];
				pack_vld[pos] = 1'b1;
				pos++;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_vld <= '0;
		else
			out_vld <= pack_vld; // one-cycle strobe, no stall.
	end

	always_ff @(posedge clk) begin
		out_e <= pack_e;
	end

	assign out_1_vld = out_vld[0];
	assign out_2_vld = out_vld[1];
	assign out_3_vld = out_vld[2];
	assign out_4_vld = out_vld[3];

	assign {out_1_des, out_1_s1, out_1_s2, out_1_op, out_1_branch, out_1_ime} = out_e[0];
	assign {out_2_des, out_2_s1, out_2_s2, out_2_op, out_2_branch, out_2_ime} = out_e[1];
	assign {out_3_des, out_3_s1, out_3_s2, out_3_op, out_3_branch, out_3_ime} = out_e[2];
	assign {out_4_des, out_4_s1, out_4_s2, out_4_op, out_4_branch, out_4_ime} = out_e[3];

endmodule

// File: verilog/stage1_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 1 top. Dispatch and issue, queue feeding hazard check and packer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "stage1_cfg.svh"

module stage1_top import isa_pkg::*, queue_pkg::*; (
	input logic clk,
	input logic arst_n,

	input logic ins_new_en, ins_new_1_vld, ins_new_2_vld,

	input reg_idx_t ins_1_des, ins_1_s1, ins_1_s2,
	input opcode_t ins_1_op,
	input imm_t ins_1_ime,

	input reg_idx_t ins_2_des, ins_2_s1, ins_2_s2,
	input opcode_t ins_2_op,
	input imm_t ins_2_ime,

	input logic ins_back_1, ins_back_2, ins_back_3, ins_back_4,
	input reg_idx_t ins_back_1_des, ins_back_2_des, ins_back_3_des, ins_back_4_des,

	input logic flush_en,
	input branch_tag_t flush_id,
	input logic [`REG_COUNT-1:0] flush_reg,

	output logic entry_full, entry_empty, branch_full,

	output logic out_1_vld,
	output reg_idx_t out_1_des, out_1_s1, out_1_s2,
	output opcode_t out_1_op,
	output branch_tag_t out_1_branch,
	output imm_t out_1_ime,

	output logic out_2_vld,
	output reg_idx_t out_2_des, out_2_s1, out_2_s2,
	output opcode_t out_2_op,
	output branch_tag_t out_2_branch,
	output imm_t out_2_ime,

	output logic out_3_vld,
	output reg_idx_t out_3_des, out_3_s1, out_3_s2,
	output opcode_t out_3_op,
	output branch_tag_t out_3_branch,
	output imm_t out_3_ime,

	output logic out_4_vld,
	output reg_idx_t out_4_des, out_4_s1, out_4_s2,
	output opcode_t out_4_op,
	output branch_tag_t out_4_branch,
	output imm_t out_4_ime
);

	// issue window, the four oldest queue entries.
	logic win_1_vld, win_2_vld, win_3_vld, win_4_vld;
	reg_idx_t win_1_des, win_2_des, win_3_des, win_4_des;
	reg_idx_t win_1_s1, win_2_s1, win_3_s1, win_4_s1;
	reg_idx_t win_1_s2, win_2_s2, win_3_s2, win_4_s2;
	opcode_t win_1_op, win_2_op, win_3_op, win_4_op;
	branch_tag_t win_1_branch, win_2_branch, win_3_branch, win_4_branch;
	imm_t win_1_ime, win_2_ime, win_3_ime, win_4_ime;

	slot_mask_t issue_mask; // window slots leaving this cycle.

	issue_queue queue_i (.*);

	hazard_checker hazard_i (.*);

	issue_swap swap_i (.*);

endmodule

// File: sim/stage1_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 1 checker. Shadow scoreboard and tag counter with issue assertions.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "stage1_cfg.svh"

module stage1_checker import isa_pkg::*, queue_pkg::*; (
	input logic clk, arst_n,
	input logic ins_new_en, ins_new_1_vld, ins_new_2_vld,
	input opcode_t ins_1_op, ins_2_op,
	input imm_t ins_1_ime, ins_2_ime,
	input logic ins_back_1, ins_back_2, ins_back_3, ins_back_4,
	input reg_idx_t ins_back_1_des, ins_back_2_des, ins_back_3_des, ins_back_4_des,
	input logic flush_en,
	input branch_tag_t flush_id,
	input logic [`REG_COUNT-1:0] flush_reg,
	input logic entry_full, entry_empty, branch_full,
	input logic out_1_vld, out_2_vld, out_3_vld, out_4_vld,
	input reg_idx_t out_1_des, out_2_des, out_3_des, out_4_des,
	input reg_idx_t out_1_s1, out_2_s1, out_3_s1, out_4_s1,
	input reg_idx_t out_1_s2, out_2_s2, out_3_s2, out_4_s2,
	input opcode_t out_1_op, out_2_op, out_3_op, out_4_op,
	input branch_tag_t out_1_branch, out_2_branch, out_3_branch, out_4_branch,
	input imm_t out_1_ime, out_2_ime, out_3_ime, out_4_ime
);

	int fails = 0;
	logic [3:0] o_vld;
	reg_idx_t o_des [4];
	reg_idx_t o_s1 [4];
	reg_idx_t o_s2 [4];
	opcode_t o_op [4];
	branch_tag_t o_br [4];
	imm_t o_ime [4];
	logic [`REG_COUNT-1:0] busy_sh, busy_nxt;
	branch_tag_t tag_sh;
	branch_tag_t tag_of [16]; // tag given at enqueue, by immediate.
	logic b1, b2, accept;

	assign o_vld = {out_4_vld, out_3_vld, out_2_vld, out_1_vld};
	assign o_des = '{out_1_des, out_2_des, out_3_des, out_4_des};
	assign o_s1 = '{out_1_s1, out_2_s1, out_3_s1, out_4_s1};
	assign o_s2 = '{out_1_s2, out_2_s2, out_3_s2, out_4_s2};
	assign o_op = '{out_1_op, out_2_op, out_3_op, out_4_op};
	assign o_br = '{out_1_branch, out_2_branch, out_3_branch, out_4_branch};
	assign o_ime = '{out_1_ime, out_2_ime, out_3_ime, out_4_ime};

	assign b1 = ins_new_1_vld && ins_1_op == OP_BRANCH;
	assign b2 = ins_new_2_vld && ins_2_op == OP_BRANCH;
	assign accept = ins_new_en && !flush_en && !entry_full && !((b1 || b2) && branch_full);

	// outputs show issues of the edge before, so later clears win here.
	always_comb begin
		busy_nxt = busy_sh;
		for (int k = 0; k < 4; k++)
			if (o_vld[k] && o_op[k] != OP_NOP)
				busy_nxt[o_des[k]] = 1'b1;
		if (ins_back_1) busy_nxt[ins_back_1_des] = 1'b0;
		if (ins_back_2) busy_nxt[ins_back_2_des] = 1'b0;
		if (ins_back_3) busy_nxt[ins_back_3_des] = 1'b0;
		if (ins_back_4) busy_nxt[ins_back_4_des] = 1'b0;
		if (flush_en)
			busy_nxt = busy_nxt & ~flush_reg;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_sh <= '0;
			tag_sh <= '0;
		end else begin
			busy_sh <= busy_nxt;
			if (flush_en)
				tag_sh <= flush_id;
			else if (accept)
				tag_sh <= tag_sh + branch_tag_t'(b1) + branch_tag_t'(b2);
		end
	end

	always_ff @(posedge clk) begin
		if (accept && ins_new_1_vld)
			tag_of[ins_1_ime] <= tag_sh;
		if (accept && ins_new_2_vld)
			tag_of[ins_2_ime] <= tag_sh + branch_tag_t'(b1);
	end

	function automatic logic dup_dest(input logic [3:0] v);
		for (int i = 0; i < 4; i++)
			for (int j = i + 1; j < 4; j++)
				if (v[i] && v[j] && o_op[i] != OP_NOP && o_op[j] != OP_NOP &&
				    o_des[i] == o_des[j])
					return 1'b1;
		return 1'b0;
	endfunction

	a_reset: assert property (@(posedge clk) arst_n && !$past(arst_n) |->
		o_vld == '0 && entry_empty && !entry_full && !branch_full)
		else begin $error("outputs or flags wrong after reset"); fails++; end

	a_packed: assert property (@(posedge clk) disable iff (!arst_n)
		(o_vld[3:1] & ~o_vld[2:0]) == '0)
		else begin $error("issue slots not packed"); fails++; end

	a_dest: assert property (@(posedge clk) disable iff (!arst_n) !dup_dest(o_vld))
		else begin $error("two slots write one destination"); fails++; end

	for (genvar k = 0; k < 4; k++) begin : g_slot
		a_busy: assert property (@(posedge clk) disable iff (!arst_n) o_vld[k] |->
			!busy_sh[o_s1[k]] && !busy_sh[o_s2[k]] && !busy_sh[o_des[k]])
			else begin $error("slot %0d issued on a busy register", k + 1); fails++; end
		a_tag: assert property (@(posedge clk) disable iff (!arst_n) o_vld[k] |->
			o_br[k] == tag_of[o_ime[k]])
			else begin $error("slot %0d carries a wrong branch tag", k + 1); fails++; end
	end

endmodule

bind stage1_top stage1_checker chk_i (.*);

// File: sim/stage1_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 1 testbench. Random dispatch, writeback and flush with a queue model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "stage1_cfg.svh"

module stage1_tb import isa_pkg::*, queue_pkg::*; ();

	localparam int PHASE_CYCLES = 150;
	localparam int TIMEOUT = 4000; // four phases plus drain, with wide margin.

	logic clk, arst_n, ins_new_en, ins_new_1_vld, ins_new_2_vld;
	reg_idx_t ins_1_des, ins_1_s1, ins_1_s2, ins_2_des, ins_2_s1, ins_2_s2;
	opcode_t ins_1_op, ins_2_op;
	imm_t ins_1_ime, ins_2_ime;
	logic ins_back_1, ins_back_2, ins_back_3, ins_back_4;
	reg_idx_t ins_back_1_des, ins_back_2_des, ins_back_3_des, ins_back_4_des;
	logic flush_en;
	branch_tag_t flush_id;
	logic [`REG_COUNT-1:0] flush_reg;
	logic entry_full, entry_empty, branch_full;
	logic out_1_vld, out_2_vld, out_3_vld, out_4_vld;
	reg_idx_t out_1_des, out_2_des, out_3_des, out_4_des;
	reg_idx_t out_1_s1, out_2_s1, out_3_s1, out_4_s1;
	reg_idx_t out_1_s2, out_2_s2, out_3_s2, out_4_s2;
	opcode_t out_1_op, out_2_op, out_3_op, out_4_op;
	branch_tag_t out_1_branch, out_2_branch, out_3_branch, out_4_branch;
	imm_t out_1_ime, out_2_ime, out_3_ime, out_4_ime;

	logic [23:0] model_q [$]; // {op, des, s1, s2, branch, tag, imm}, oldest first.
	branch_tag_t model_tag;
	int wb_due [$];
	reg_idx_t wb_reg [$];
	reg_idx_t last_des;
	int errors = 0;
	int cycle = 0;
	int cycles_run = 0;
	int total;

	stage1_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles_run++;
		if (cycles_run >= TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Errors found");
			$finish;
		end
	end

	task automatic report(input string msg);
		errors++;
		$display("[ERROR] %0t %s", $time, msg);
	endtask

	function automatic int branches_queued();
		int n = 0;
		foreach (model_q[i]) n += model_q[i][7];
		return n;
	endfunction

	function automatic imm_t free_imm(input imm_t skip);
		int start = $urandom % 16;
		logic used;
		for (int i = 0; i < 16; i++) begin
			used = imm_t'(start + i) == skip;
			foreach (model_q[j]) if (model_q[j][3:0] == imm_t'(start + i)) used = 1'b1;
			if (!used) return imm_t'(start + i);
		end
		return skip;
	endfunction

	// issued entries leave the model; an unknown immediate is an error.
	task automatic observe_issue();
		logic [3:0] vld;
		imm_t ime [4];
		opcode_t op [4];
		reg_idx_t des [4];
		reg_idx_t s1 [4];
		reg_idx_t s2 [4];
		int found;
		vld = {out_4_vld, out_3_vld, out_2_vld, out_1_vld};
		ime = '{out_1_ime, out_2_ime, out_3_ime, out_4_ime};
		op = '{out_1_op, out_2_op, out_3_op, out_4_op};
		des = '{out_1_des, out_2_des, out_3_des, out_4_des};
		s1 = '{out_1_s1, out_2_s1, out_3_s1, out_4_s1};
		s2 = '{out_1_s2, out_2_s2, out_3_s2, out_4_s2};
		for (int k = 0; k < 4; k++) begin
			if (!vld[k]) continue;
			found = -1;
			foreach (model_q[i]) if (found < 0 && model_q[i][3:0] == ime[k]) found = i;
			if (found < 0) begin
				report($sformatf("slot %0d issued imm %0d not in the queue", k + 1, ime[k]));
			end else begin
				if (model_q[found][23:8] !== {op[k], des[k], s1[k], s2[k]})
					report($sformatf("slot %0d imm %0d issued with wrong fields",
						k + 1, ime[k]));
				model_q.delete(found);
				if (op[k] != OP_NOP) begin
					wb_due.push_back(cycle + 1 + int'($urandom % 4));
					wb_reg.push_back(des[k]);
				end
			end
		end
		if (entry_empty !== (model_q.size() == 0) || entry_full !== (model_q.size() > 14) ||
		    branch_full !== (branches_queued() >= `BRANCH_LIMIT))
			report($sformatf("flags do not match a model count of %0d", model_q.size()));
	endtask

	task automatic drive_writeback();
		logic [3:0] b = '0;
		reg_idx_t d [4] = '{default: '0};
		int n = 0;
		int i = 0;
		while (i < wb_due.size()) begin
			if (wb_due[i] <= cycle && n < 4) begin
				b[n] = 1'b1;
				d[n] = wb_reg[i];
				n++;
				wb_due.delete(i);
				wb_reg.delete(i);
			end else i++;
		end
		{ins_back_4, ins_back_3, ins_back_2, ins_back_1} = b;
		{ins_back_1_des, ins_back_2_des, ins_back_3_des, ins_back_4_des} = {d[0], d[1], d[2], d[3]};
	endtask

	task automatic drive_input(input int phase);
		int cut;
		logic b1, b2, acc;
		branch_tag_t t;
		flush_en = 1'b0;
		if (phase == 4 && model_q.size() > 0 && $urandom % 8 == 0) begin
			flush_en = 1'b1;
			flush_id = model_q[$urandom % model_q.size()][6:4];
			flush_reg = `REG_COUNT'($urandom);
			cut = -1;
			foreach (model_q[i]) if (cut < 0 && model_q[i][6:4] == flush_id) cut = i;
			while (model_q.size() > cut) void'(model_q.pop_back());
			model_tag = flush_id;
		end
		ins_new_en = phase < 5 && $urandom % 4 != 0;
		ins_new_1_vld = $urandom % 8 != 0;
		ins_new_2_vld = $urandom % 2;
		ins_1_ime = free_imm(imm_t'(0));
		ins_2_ime = free_imm(ins_1_ime);
		ins_1_op = (phase == 3 || phase == 4) && $urandom % 3 == 0 ? OP_BRANCH :
			opcode_t'($urandom % 15);
		ins_2_op = phase == 3 && $urandom % 2 == 0 ? OP_BRANCH : opcode_t'($urandom % 15);
		{ins_1_des, ins_1_s1, ins_1_s2} = 12'($urandom);
		{ins_2_des, ins_2_s1, ins_2_s2} = 12'($urandom);
		if (phase == 2) begin // chains through the previous destination.
			ins_1_s1 = last_des;
			ins_2_s1 = ins_1_des;
		end
		b1 = ins_new_1_vld && ins_1_op == OP_BRANCH;
		b2 = ins_new_2_vld && ins_2_op == OP_BRANCH;
		acc = ins_new_en && !flush_en && model_q.size() <= 14 &&
			!((b1 || b2) && branches_queued() >= `BRANCH_LIMIT);
		if (acc) begin
			t = model_tag;
			if (ins_new_1_vld)
				model_q.push_back({ins_1_op, ins_1_des, ins_1_s1, ins_1_s2, b1, t, ins_1_ime});
			t = t + branch_tag_t'(b1);
			if (ins_new_2_vld)
				model_q.push_back({ins_2_op, ins_2_des, ins_2_s1, ins_2_s2, b2, t, ins_2_ime});
			model_tag = t + branch_tag_t'(b2);
			last_des = ins_new_2_vld ? ins_2_des : ins_1_des;
		end
	endtask

	task automatic step(input int phase);
		@(posedge clk);
		@(negedge clk);
		cycle++;
		observe_issue();
		drive_writeback();
		drive_input(phase);
	endtask

	initial begin
		void'($urandom(50985));
		arst_n = 1'b0;
		{ins_new_en, ins_new_1_vld, ins_new_2_vld, flush_en} = '0;
		{ins_1_des, ins_1_s1, ins_1_s2, ins_2_des, ins_2_s1, ins_2_s2} = '0;
		{ins_1_op, ins_2_op, ins_1_ime, ins_2_ime, flush_id, flush_reg} = '0;
		{ins_back_1, ins_back_2, ins_back_3, ins_back_4} = '0;
		{ins_back_1_des, ins_back_2_des, ins_back_3_des, ins_back_4_des} = '0;
		model_tag = '0;
		last_des = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int p = 1; p <= 4; p++)
			repeat (PHASE_CYCLES) step(p);
		step(5);
		while (!entry_empty || wb_due.size() > 0)
			step(5);
		repeat (8) step(5);
		if (model_q.size() != 0)
			report($sformatf("%0d instructions never issued", model_q.size()));
		total = errors + dut_i.chk_i.fails;
		$display("model errors %0d, assertion failures %0d", errors, dut_i.chk_i.fails);
		if (total == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: list.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/queue_pkg.sv
verilog/issue_queue.sv
verilog/hazard_checker.sv
verilog/issue_swap.sv
verilog/stage1_top.sv
sim/stage1_checker.sv
sim/stage1_tb.sv

// File: Makefile
# Verilator build and run for the stage 1 dispatch and issue testbench.

VERILATOR ?= verilator
TOP       ?= stage1_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 1000
VFLAGS    ?= --binary --assert --timing -Wno-fatal

SRCS := $(shell grep -v '^+' list.f)
HDRS := $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) +verilator+error+limit+$(ERR_LIMIT) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
